// File: build.f
src/soc_pkg.sv
src/wb_master_ctrl.sv
src/wb_addr_decoder.sv
src/wb_data_mem.sv
src/wb_mtimer.sv
src/wb_gpio.sv
src/wb_soc_top.sv
verification/tb_wb_soc.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_wb_soc -Mdir obj_dir -f build.f

sim_out=$(./obj_dir/Vtb_wb_soc)
printf '%s\n' "$sim_out"

# status comes from the pass message
printf '%s\n' "$sim_out" | grep -q "Simulation completed successfully"

// File: src/soc_pkg.sv
package soc_pkg;

  // ========================================
  // bus widths
  // ========================================
  localparam int XLEN       = 32;
  localparam int SEL_W      = XLEN / 8;
  // data memory depth in words, 1 KiB
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // ========================================
  // memory map
  // ========================================
  // top nibble of the address picks the region
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 28;

  localparam logic [3:0] REGION_DMEM  = 4'h0;
  localparam logic [3:0] REGION_TIMER = 4'h2;
  localparam logic [3:0] REGION_GPIO  = 4'h3;

  // timer register offsets
  localparam logic [3:0] TIMER_MTIME_LO    = 4'h0;
  localparam logic [3:0] TIMER_MTIME_HI    = 4'h4;
  localparam logic [3:0] TIMER_MTIMECMP_LO = 4'h8;
  localparam logic [3:0] TIMER_MTIMECMP_HI = 4'hC;

  // gpio register offsets
  localparam logic [3:0] GPIO_OUT = 4'h0;
  localparam logic [3:0] GPIO_IN  = 4'h4;
  localparam logic [3:0] GPIO_DIR = 4'h8;

  // load/store width codes, same as rv32i funct3
  localparam logic [2:0] OP_B  = 3'b000;
  localparam logic [2:0] OP_H  = 3'b001;
  localparam logic [2:0] OP_W  = 3'b010;
  localparam logic [2:0] OP_BU = 3'b100;
  localparam logic [2:0] OP_HU = 3'b101;

  // bus master states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACCESS = 2'd1,
    DONE   = 2'd2
  } mst_state_t;

  // byte-lane merge for register writes
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0]  old_v,
                                                  input logic [XLEN-1:0]  new_v,
                                                  input logic [SEL_W-1:0] sel);
    logic [XLEN-1:0] res;
    res = old_v;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

endpackage

// File: src/wb_addr_decoder.sv
`timescale 1ns/10ps

module wb_addr_decoder (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // master side
  input  logic [soc_pkg::XLEN-1:0] m_adr_i,
  input  logic                     m_stb_i,
  input  logic                     m_cyc_i,
  output logic [soc_pkg::XLEN-1:0] m_dat_o,
  output logic                     m_ack_o,
  output logic                     m_err_o,
  // data memory
  output logic                     dmem_stb_o,
  input  logic [soc_pkg::XLEN-1:0] dmem_dat_i,
  input  logic                     dmem_ack_i,
  // machine timer
  output logic                     tmr_stb_o,
  input  logic [soc_pkg::XLEN-1:0] tmr_dat_i,
  input  logic                     tmr_ack_i,
  // gpio block
  output logic                     gpio_stb_o,
  input  logic [soc_pkg::XLEN-1:0] gpio_dat_i,
  input  logic                     gpio_ack_i
);

  logic [3:0] region;
  logic       active;
  logic       unmapped;
  logic       err_q;

  assign region = m_adr_i[soc_pkg::REGION_MSB:soc_pkg::REGION_LSB];
  assign active = m_cyc_i & m_stb_i;

  // ========================================
  // strobe decode
  // ========================================
  assign dmem_stb_o = active & (region == soc_pkg::REGION_DMEM);
  assign tmr_stb_o  = active & (region == soc_pkg::REGION_TIMER);
  assign gpio_stb_o = active & (region == soc_pkg::REGION_GPIO);
  assign unmapped   = active & ~(dmem_stb_o | tmr_stb_o | gpio_stb_o);

  // ========================================
  // return path
  // ========================================
  always_comb begin
    case (region)
      soc_pkg::REGION_DMEM: begin
        m_dat_o = dmem_dat_i;
        m_ack_o = dmem_ack_i;
      end
      soc_pkg::REGION_TIMER: begin
        m_dat_o = tmr_dat_i;
        m_ack_o = tmr_ack_i;
      end
      soc_pkg::REGION_GPIO: begin
        m_dat_o = gpio_dat_i;
        m_ack_o = gpio_ack_i;
      end
      // nothing lives here
      default: begin
        m_dat_o = '0;
        m_ack_o = 1'b0;
      end
    endcase
  end

  // unmapped access, one-cycle err pulse like a slave ack
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped & ~err_q;
    end
  end

  assign m_err_o = err_q;

  a_stb_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({dmem_stb_o, tmr_stb_o, gpio_stb_o}));

endmodule

// File: src/wb_data_mem.sv
`timescale 1ns/10ps

module wb_data_mem (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [soc_pkg::XLEN-1:0]  adr_i,
  input  logic [soc_pkg::XLEN-1:0]  dat_i,
  input  logic [soc_pkg::SEL_W-1:0] sel_i,
  input  logic                      we_i,
  input  logic                      stb_i,
  output logic [soc_pkg::XLEN-1:0]  dat_o,
  output logic                      ack_o
);

  // word storage
  logic [soc_pkg::XLEN-1:0]    mem [soc_pkg::DMEM_WORDS];
  logic [soc_pkg::DMEM_AW-1:0] idx;
  logic                        access;

  // word index from bits 9:2
  assign idx = adr_i[soc_pkg::DMEM_AW+1:2];

  // first cycle of a strobe only, the ack cycle is not a new access
  assign access = stb_i & ~ack_o;

  // ========================================
  // array write and registered read
  // ========================================
  always_ff @(posedge clk) begin
    if (access) begin
      if (we_i) begin
        // byte-masked store
        for (int b = 0; b < soc_pkg::SEL_W; b++) begin
          if (sel_i[b]) mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
      dat_o <= mem[idx];
    end
  end

  // single-cycle ack pulse
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // an ack always answers the strobe of the cycle before
  a_ack_after_stb : assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_o |-> $past(stb_i));

endmodule

// File: src/wb_gpio.sv
`timescale 1ns/10ps

module wb_gpio (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [soc_pkg::XLEN-1:0]  adr_i,
  input  logic [soc_pkg::XLEN-1:0]  dat_i,
  input  logic [soc_pkg::SEL_W-1:0] sel_i,
  input  logic                      we_i,
  input  logic                      stb_i,
  output logic [soc_pkg::XLEN-1:0]  dat_o,
  output logic                      ack_o,
  input  logic [soc_pkg::XLEN-1:0]  gpio_i,
  output logic [soc_pkg::XLEN-1:0]  gpio_o,
  output logic [soc_pkg::XLEN-1:0]  gpio_oe_o
);

  logic [soc_pkg::XLEN-1:0] in_meta;
  logic [soc_pkg::XLEN-1:0] in_sync;
  logic                     access;
  logic                     wr;

  assign access = stb_i & ~ack_o;
  assign wr     = access & we_i;

  // ========================================
  // registers and input sync
  // ========================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o    <= '0;
      gpio_oe_o <= '0;
      in_meta   <= '0;
      in_sync   <= '0;
      ack_o     <= 1'b0;
    end else begin
      ack_o   <= access;
      // two flops, pins are asynchronous
      in_meta <= gpio_i;
      in_sync <= in_meta;
      if (wr && adr_i[3:0] == soc_pkg::GPIO_OUT) begin
        gpio_o <= soc_pkg::merge_bytes(gpio_o, dat_i, sel_i);
      end
      if (wr && adr_i[3:0] == soc_pkg::GPIO_DIR) begin
        gpio_oe_o <= soc_pkg::merge_bytes(gpio_oe_o, dat_i, sel_i);
      end
      // GPIO_IN is read only, writes fall through
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (adr_i[3:0])
        soc_pkg::GPIO_OUT: dat_o <= gpio_o;
        soc_pkg::GPIO_IN:  dat_o <= in_sync;
        soc_pkg::GPIO_DIR: dat_o <= gpio_oe_o;
        default:           dat_o <= '0;
      endcase
    end
  end

endmodule

// File: src/wb_master_ctrl.sv
`timescale 1ns/10ps

module wb_master_ctrl (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // processor memory port
  input  logic [soc_pkg::XLEN-1:0] proc_addr_i,
  input  logic [soc_pkg::XLEN-1:0] proc_wdata_i,
  input  logic                     proc_read_i,
  input  logic                     proc_write_i,
  input  logic [2:0]               proc_op_i,
  output logic [soc_pkg::XLEN-1:0] proc_rdata_o,
  output logic                     proc_stall_o,
  output logic                     proc_err_o,
  // wishbone master side
  output logic [soc_pkg::XLEN-1:0]  wb_adr_o,
  output logic [soc_pkg::XLEN-1:0]  wb_dat_o,
  output logic [soc_pkg::SEL_W-1:0] wb_sel_o,
  output logic                      wb_we_o,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  input  logic [soc_pkg::XLEN-1:0]  wb_dat_i,
  input  logic                      wb_ack_i,
  input  logic                      wb_err_i
);

  soc_pkg::mst_state_t state_q;
  logic                      req;
  logic                      done_in;
  logic [soc_pkg::SEL_W-1:0] sel_c;
  logic [soc_pkg::XLEN-1:0]  wdat_c;
  logic [soc_pkg::XLEN-1:0]  lane_c;
  logic [soc_pkg::XLEN-1:0]  load_c;

  assign req     = proc_read_i | proc_write_i;
  assign done_in = wb_ack_i | wb_err_i;

  // ========================================
  // store lane steering
  // ========================================
  always_comb begin
    case (proc_op_i)
      soc_pkg::OP_B, soc_pkg::OP_BU: begin
        sel_c  = 4'b0001 << proc_addr_i[1:0];
        wdat_c = {4{proc_wdata_i[7:0]}};
      end
      soc_pkg::OP_H, soc_pkg::OP_HU: begin
        sel_c  = 4'b0011 << {proc_addr_i[1], 1'b0};
        wdat_c = {2{proc_wdata_i[15:0]}};
      end
      default: begin
        sel_c  = 4'b1111;
        wdat_c = proc_wdata_i;
      end
    endcase
  end

  // ========================================
  // load alignment and extension
  // ========================================
  // request fields are still held while ack is in flight
  always_comb begin
    lane_c = wb_dat_i >> {proc_addr_i[1:0], 3'b000};
    case (proc_op_i)
      soc_pkg::OP_B:  load_c = {{(soc_pkg::XLEN-8){lane_c[7]}}, lane_c[7:0]};
      soc_pkg::OP_BU: load_c = {{(soc_pkg::XLEN-8){1'b0}}, lane_c[7:0]};
      soc_pkg::OP_H:  load_c = {{(soc_pkg::XLEN-16){lane_c[15]}}, lane_c[15:0]};
      soc_pkg::OP_HU: load_c = {{(soc_pkg::XLEN-16){1'b0}}, lane_c[15:0]};
      default:        load_c = lane_c;
    endcase
  end

  // ========================================
  // cycle state machine
  // ========================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= soc_pkg::IDLE;
      wb_cyc_o   <= 1'b0;
      wb_stb_o   <= 1'b0;
      proc_err_o <= 1'b0;
    end else begin
      case (state_q)
        soc_pkg::IDLE: begin
          if (req) begin
            state_q  <= soc_pkg::ACCESS;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
          end
        end
        soc_pkg::ACCESS: begin
          // hold the cycle until the slave or decoder terminates it
          if (done_in) begin
            state_q    <= soc_pkg::DONE;
            wb_cyc_o   <= 1'b0;
            wb_stb_o   <= 1'b0;
            proc_err_o <= wb_err_i;
          end
        end
        default: begin
          state_q    <= soc_pkg::IDLE;
          proc_err_o <= 1'b0;
        end
      endcase
    end
  end

  // request payload, latched at launch
  always_ff @(posedge clk) begin
    if (state_q == soc_pkg::IDLE && req) begin
      wb_adr_o <= {proc_addr_i[soc_pkg::XLEN-1:2], 2'b00};
      wb_dat_o <= wdat_c;
      wb_sel_o <= sel_c;
      wb_we_o  <= proc_write_i;
    end
    // read data captured on termination, zero on err
    if (state_q == soc_pkg::ACCESS && done_in) begin
      proc_rdata_o <= wb_err_i ? '0 : load_c;
    end
  end

  // stall until the done cycle
  assign proc_stall_o = req & (state_q != soc_pkg::DONE);

  // ========================================
  // checks
  // ========================================
  a_cyc_stb : assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_cyc_o == wb_stb_o);
  a_no_rw : assert property (@(posedge clk) disable iff (!rst_n_i)
    !(proc_read_i && proc_write_i));
  a_ack_err : assert property (@(posedge clk) disable iff (!rst_n_i)
    !(wb_ack_i && wb_err_i));

endmodule

// File: src/wb_mtimer.sv
`timescale 1ns/10ps

module wb_mtimer (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic [soc_pkg::XLEN-1:0]  adr_i,
  input  logic [soc_pkg::XLEN-1:0]  dat_i,
  input  logic [soc_pkg::SEL_W-1:0] sel_i,
  input  logic                      we_i,
  input  logic                      stb_i,
  output logic [soc_pkg::XLEN-1:0]  dat_o,
  output logic                      ack_o,
  output logic                      mtip_o
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [3:0]  offs;
  logic        access;
  logic        wr;

  assign offs   = adr_i[3:0];
  assign access = stb_i & ~ack_o;
  assign wr     = access & we_i;

  // ========================================
  // counter, compare and interrupt
  // ========================================
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime    <= '0;
      // all ones keeps mtip low out of reset
      mtimecmp <= '1;
      mtip_o   <= 1'b0;
      ack_o    <= 1'b0;
    end else begin
      ack_o  <= access;
      mtip_o <= (mtime >= mtimecmp);
      // free running
      mtime  <= mtime + 64'd1;
      // a bus write overrides the half it targets
      if (wr && offs == soc_pkg::TIMER_MTIME_LO) begin
        mtime[31:0] <= soc_pkg::merge_bytes(mtime[31:0], dat_i, sel_i);
      end
      if (wr && offs == soc_pkg::TIMER_MTIME_HI) begin
        mtime[63:32] <= soc_pkg::merge_bytes(mtime[63:32], dat_i, sel_i);
      end
      if (wr && offs == soc_pkg::TIMER_MTIMECMP_LO) begin
        mtimecmp[31:0] <= soc_pkg::merge_bytes(mtimecmp[31:0], dat_i, sel_i);
      end
      if (wr && offs == soc_pkg::TIMER_MTIMECMP_HI) begin
        mtimecmp[63:32] <= soc_pkg::merge_bytes(mtimecmp[63:32], dat_i, sel_i);
      end
    end
  end

  // ========================================
  // read mux
  // ========================================
  always_ff @(posedge clk) begin
    if (access) begin
      case (offs)
        soc_pkg::TIMER_MTIME_LO:    dat_o <= mtime[31:0];
        soc_pkg::TIMER_MTIME_HI:    dat_o <= mtime[63:32];
        soc_pkg::TIMER_MTIMECMP_LO: dat_o <= mtimecmp[31:0];
        soc_pkg::TIMER_MTIMECMP_HI: dat_o <= mtimecmp[63:32];
        default:                    dat_o <= '0;
      endcase
    end
  end

endmodule

// File: src/wb_soc_top.sv
`timescale 1ns/10ps

module wb_soc_top (
  input  logic                     clk,
  input  logic                     rst_n_i,
  // processor memory port
  input  logic [soc_pkg::XLEN-1:0] proc_addr_i,
  input  logic [soc_pkg::XLEN-1:0] proc_wdata_i,
  input  logic                     proc_read_i,
  input  logic                     proc_write_i,
  input  logic [2:0]               proc_op_i,
  output logic [soc_pkg::XLEN-1:0] proc_rdata_o,
  output logic                     proc_stall_o,
  output logic                     proc_err_o,
  // peripherals
  input  logic [soc_pkg::XLEN-1:0] gpio_i,
  output logic [soc_pkg::XLEN-1:0] gpio_o,
  output logic [soc_pkg::XLEN-1:0] gpio_oe_o,
  output logic                     mtip_o
);

  // ========================================
  // shared bus
  // ========================================
  logic [soc_pkg::XLEN-1:0]  wb_adr;
  logic [soc_pkg::XLEN-1:0]  wb_dat_w;
  logic [soc_pkg::SEL_W-1:0] wb_sel;
  logic                      wb_we;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic [soc_pkg::XLEN-1:0]  wb_dat_r;
  logic                      wb_ack;
  logic                      wb_err;

  // per-slave strobe and return
  logic                     dmem_stb;
  logic [soc_pkg::XLEN-1:0] dmem_dat;
  logic                     dmem_ack;
  logic                     tmr_stb;
  logic [soc_pkg::XLEN-1:0] tmr_dat;
  logic                     tmr_ack;
  logic                     gpio_stb;
  logic [soc_pkg::XLEN-1:0] gpio_dat;
  logic                     gpio_ack;

  wb_master_ctrl u_master (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .proc_addr_i  (proc_addr_i),
    .proc_wdata_i (proc_wdata_i),
    .proc_read_i  (proc_read_i),
    .proc_write_i (proc_write_i),
    .proc_op_i    (proc_op_i),
    .proc_rdata_o (proc_rdata_o),
    .proc_stall_o (proc_stall_o),
    .proc_err_o   (proc_err_o),
    .wb_adr_o     (wb_adr),
    .wb_dat_o     (wb_dat_w),
    .wb_sel_o     (wb_sel),
    .wb_we_o      (wb_we),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_dat_i     (wb_dat_r),
    .wb_ack_i     (wb_ack),
    .wb_err_i     (wb_err)
  );

  wb_addr_decoder u_decoder (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .m_adr_i    (wb_adr),
    .m_stb_i    (wb_stb),
    .m_cyc_i    (wb_cyc),
    .m_dat_o    (wb_dat_r),
    .m_ack_o    (wb_ack),
    .m_err_o    (wb_err),
    .dmem_stb_o (dmem_stb),
    .dmem_dat_i (dmem_dat),
    .dmem_ack_i (dmem_ack),
    .tmr_stb_o  (tmr_stb),
    .tmr_dat_i  (tmr_dat),
    .tmr_ack_i  (tmr_ack),
    .gpio_stb_o (gpio_stb),
    .gpio_dat_i (gpio_dat),
    .gpio_ack_i (gpio_ack)
  );

  // ========================================
  // slaves
  // ========================================
  wb_data_mem u_dmem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .adr_i   (wb_adr),
    .dat_i   (wb_dat_w),
    .sel_i   (wb_sel),
    .we_i    (wb_we),
    .stb_i   (dmem_stb),
    .dat_o   (dmem_dat),
    .ack_o   (dmem_ack)
  );

  wb_mtimer u_timer (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .adr_i   (wb_adr),
    .dat_i   (wb_dat_w),
    .sel_i   (wb_sel),
    .we_i    (wb_we),
    .stb_i   (tmr_stb),
    .dat_o   (tmr_dat),
    .ack_o   (tmr_ack),
    .mtip_o  (mtip_o)
  );

  wb_gpio u_gpio (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .adr_i     (wb_adr),
    .dat_i     (wb_dat_w),
    .sel_i     (wb_sel),
    .we_i      (wb_we),
    .stb_i     (gpio_stb),
    .dat_o     (gpio_dat),
    .ack_o     (gpio_ack),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

// File: verification/tb_wb_soc.sv
`timescale 1ns/10ps

module tb_wb_soc;

  logic        clk;
  logic        rst_n_i;
  logic [31:0] proc_addr_i;
  logic [31:0] proc_wdata_i;
  logic        proc_read_i;
  logic        proc_write_i;
  logic [2:0]  proc_op_i;
  logic [31:0] proc_rdata_o;
  logic        proc_stall_o;
  logic        proc_err_o;
  logic [31:0] gpio_i;
  logic [31:0] gpio_o;
  logic [31:0] gpio_oe_o;
  logic        mtip_o;

  // parsed stimulus, one entry per command
  logic [7:0]  cmd_q  [$];
  logic [31:0] arg0_q [$];
  logic [31:0] arg1_q [$];
  logic [31:0] arg2_q [$];

  int          mismatches;
  int          other_errs;
  int          cycles;
  int          cycle_limit;
  logic        limit_ready;
  logic        have_prev;
  logic [31:0] prev_mtime;

  wb_soc_top u_wb_soc_top (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .proc_addr_i  (proc_addr_i),
    .proc_wdata_i (proc_wdata_i),
    .proc_read_i  (proc_read_i),
    .proc_write_i (proc_write_i),
    .proc_op_i    (proc_op_i),
    .proc_rdata_o (proc_rdata_o),
    .proc_stall_o (proc_stall_o),
    .proc_err_o   (proc_err_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .mtip_o       (mtip_o)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      mismatches++;
    end
  endtask

  // one processor access, called on a falling edge, returns on a falling edge
  task automatic bus_access(input logic wr, input logic [2:0] op, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int                  waits;
    soc_pkg::mst_state_t st;
    proc_addr_i  = addr;
    proc_wdata_i = wdata;
    proc_op_i    = op;
    proc_read_i  = ~wr;
    proc_write_i = wr;
    waits        = 0;
    // wait for the completion cycle, bounded
    do begin
      @(negedge clk);
      waits++;
    end while (proc_stall_o && waits < 8);
    if (proc_stall_o) begin
      st = u_wb_soc_top.u_master.state_q;
      $display("stall never ended for access to %h, master in %s", addr, st.name());
      other_errs++;
    end else if (waits != 3) begin
      // three cycles from request edge to completion
      $display("MISMATCH access_latency got %h expected %h", waits, 3);
      mismatches++;
    end
    rdata = proc_rdata_o;
    err   = proc_err_o;
    // hold through the completion cycle, then release
    @(negedge clk);
    proc_read_i  = 1'b0;
    proc_write_i = 1'b0;
  endtask

  // ========================================
  // stimulus file
  // ========================================
  task automatic load_stimulus();
    int          fd;
    int          rc;
    int          ch;
    logic [7:0]  c;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    fd = $fopen("verification/wb_soc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("stimulus file could not be opened");
      other_errs++;
      return;
    end
    rc = $fscanf(fd, " %c", c);
    while (rc == 1) begin
      v0 = '0;
      v1 = '0;
      v2 = '0;
      if (c == "#") begin
        // comment line, skip to newline
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        if (c == "W" || c == "R") begin
          rc = $fscanf(fd, "%h %h %h", v0, v1, v2);
        end else if (c == "E" || c == "M" || c == "G") begin
          rc = $fscanf(fd, "%h", v0);
        end else if (c != "C") begin
          $display("unknown command %c in stimulus file", c);
          other_errs++;
        end
        cmd_q.push_back(c);
        arg0_q.push_back(v0);
        arg1_q.push_back(v1);
        arg2_q.push_back(v2);
      end
      rc = $fscanf(fd, " %c", c);
    end
    $fclose(fd);
  endtask

  task automatic run_command(input int i);
    logic [7:0]  c;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] rd;
    logic        err;
    c  = cmd_q[i];
    a0 = arg0_q[i];
    a1 = arg1_q[i];
    a2 = arg2_q[i];
    case (c)
      "W": begin
        bus_access(1'b1, a0[2:0], a1, a2, rd, err);
        compare_word("proc_err_o", {31'b0, err}, 32'h0);
        // full-word gpio writes show up on the pins
        if (a1[31:28] == soc_pkg::REGION_GPIO && a0[2:0] == soc_pkg::OP_W) begin
          if (a1[3:0] == soc_pkg::GPIO_OUT) begin
            compare_word("gpio_o", gpio_o, a2);
          end
          if (a1[3:0] == soc_pkg::GPIO_DIR) begin
            compare_word("gpio_oe_o", gpio_oe_o, a2);
          end
        end
      end
      "R": begin
        bus_access(1'b0, a0[2:0], a1, 32'h0, rd, err);
        compare_word("proc_err_o", {31'b0, err}, 32'h0);
        compare_word("proc_rdata_o", rd, a2);
      end
      "E": begin
        // unmapped, err with zero data
        bus_access(1'b0, soc_pkg::OP_W, a0, 32'h0, rd, err);
        compare_word("proc_err_o", {31'b0, err}, 32'h1);
        compare_word("proc_rdata_o", rd, 32'h0);
      end
      "M": compare_word("mtip_o", {31'b0, mtip_o}, a0);
      "G": gpio_i = a0;
      "C": begin
        bus_access(1'b0, soc_pkg::OP_W,
                   {soc_pkg::REGION_TIMER, 24'h0, soc_pkg::TIMER_MTIME_LO}, 32'h0, rd, err);
        compare_word("proc_err_o", {31'b0, err}, 32'h0);
        if (have_prev && rd < prev_mtime) begin
          $display("MISMATCH mtime_lo got %h expected at least %h", rd, prev_mtime);
          mismatches++;
        end
        have_prev  = 1'b1;
        prev_mtime = rd;
      end
      default: other_errs++;
    endcase
  endtask

  // 16 pseudo-random words, regenerated for the expected values
  task automatic lcg_readback();
    logic [31:0] seed;
    logic [31:0] rd;
    logic        err;
    seed = 32'h22bd;
    for (int k = 0; k < 16; k++) begin
      seed = lcg_next(seed);
      bus_access(1'b1, soc_pkg::OP_W, 32'h200 + 4 * k, seed, rd, err);
    end
    seed = 32'h22bd;
    for (int k = 0; k < 16; k++) begin
      seed = lcg_next(seed);
      bus_access(1'b0, soc_pkg::OP_W, 32'h200 + 4 * k, 32'h0, rd, err);
      compare_word("proc_rdata_o", rd, seed);
    end
  endtask

  // ========================================
  // timeout and main sequence
  // ========================================
  initial begin
    cycles = 0;
    wait (limit_ready);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    limit_ready  = 1'b0;
    rst_n_i      = 1'b0;
    proc_addr_i  = '0;
    proc_wdata_i = '0;
    proc_read_i  = 1'b0;
    proc_write_i = 1'b0;
    proc_op_i    = soc_pkg::OP_W;
    gpio_i       = '0;
    mismatches   = 0;
    other_errs   = 0;
    have_prev    = 1'b0;
    prev_mtime   = '0;
    load_stimulus();
    // lcg phase counts as 32 more commands
    cycle_limit = (cmd_q.size() + 32) * 10 + 200;
    limit_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    // quiet outputs out of reset
    compare_word("proc_stall_o", {31'b0, proc_stall_o}, 32'h0);
    compare_word("gpio_o", gpio_o, 32'h0);
    compare_word("gpio_oe_o", gpio_oe_o, 32'h0);
    for (int i = 0; i < cmd_q.size(); i++) begin
      run_command(i);
    end
    lcg_readback();
    $display("commands %0d, mismatches %0d, other errors %0d",
             cmd_q.size(), mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verification/wb_soc_stimulus.txt
# W op addr data, R op addr expected, E addr (unmapped), M mtip expected
# G gpio_i value, C mtime_lo read that must not decrease; all values hex
M 0
W 2 00000000 deadbeef
W 2 00000004 12345678
W 2 000003fc a5a55a5a
R 2 00000000 deadbeef
R 2 00000004 12345678
R 2 000003fc a5a55a5a
W 2 00000040 11223344
W 0 00000041 000000aa
W 1 00000042 0000beef
R 2 00000040 beefaa44
R 0 00000041 ffffffaa
R 4 00000041 000000aa
R 1 00000042 ffffbeef
R 5 00000042 0000beef
R 0 00000040 00000044
R 1 00000040 ffffaa44
W 2 30000000 000000ff
W 2 30000008 0000000f
R 2 30000000 000000ff
G c3c3c3c3
R 2 00000000 deadbeef
R 2 30000004 c3c3c3c3
W 2 30000004 00000000
R 2 30000004 c3c3c3c3
C
R 2 00000004 12345678
C
W 2 2000000c 00000000
W 2 20000008 00000000
R 2 00000000 deadbeef
M 1
W 2 2000000c ffffffff
W 2 20000008 ffffffff
R 2 00000000 deadbeef
M 0
E 10000000
R 2 00000004 12345678
